/* project.f */
+incdir+verilog
verilog/vec_isa_pkg.sv
verilog/vec_lane_pkg.sv
verilog/vec_dispatcher.sv
verilog/vec_sequencer.sv
verilog/vec_lane.sv
verilog/vec_masku.sv
verilog/vec_top.sv
verif/vec_tb.sv

/* Makefile */
SIM       ?= verilator
SIMFLAGS  ?= --binary --timing -j 0
TOP       ?= vec_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard verilog/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TESTS PASSED'

clean:
	rm -rf $(BUILD_DIR)

/* verif/vec_tb.sv */
// Vector accelerator testbench
// Requests from a table checked against a register-file model
// Responses are held back at random

`timescale 1ns/1ps
`include "vec_config.svh"

module vec_tb import vec_isa_pkg::*; ();

  typedef struct packed {
    acc_req_t  req;
    acc_resp_t exp;
  } stim_entry_t;

  logic      clk_i;
  logic      rst_i;
  acc_req_t  acc_req_i;
  logic      acc_req_valid_i;
  logic      acc_req_ready_o;
  acc_resp_t acc_resp_o;
  logic      acc_resp_valid_o;
  logic      acc_resp_ready_i;

  stim_entry_t stim_q [$];
  elem_t       model_vrf [`VEC_NR_VREGS][`VEC_VLMAX];
  int          model_vl;
  integer      seed = 29;
  bit          table_built = 1'b0;
  int          resp_errors = 0;
  int          ready_errors = 0;
  int          proto_errors = 0;

  vec_top vec_top_inst (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .acc_req_i        (acc_req_i),
    .acc_req_valid_i  (acc_req_valid_i),
    .acc_req_ready_o  (acc_req_ready_o),
    .acc_resp_o       (acc_resp_o),
    .acc_resp_valid_o (acc_resp_valid_o),
    .acc_resp_ready_i (acc_resp_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and stimulus table
  ////////////////////////////////////////////////////////////////////////////

  function automatic elem_t rand_elem();
    return elem_t'($random(seed));
  endfunction

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // Applies one instruction to the model and records it with its expected result
  function automatic void add_entry(input vec_op_e op, input int vd, input int vs1,
                                    input int vs2, input elem_t scalar);
    stim_entry_t ent;
    elem_t       res;
    int          ones;
    int          idx;
    res  = '0;
    ones = 0;
    idx  = int'(scalar);
    case (op)
      VSETVL: begin
        model_vl = (scalar > elem_t'(`VEC_VLMAX)) ? `VEC_VLMAX : idx;
        res      = elem_t'(model_vl);
      end
      VCPOP: begin
        for (int i = 0; i < model_vl; i++) begin
          ones += int'(model_vrf[vs2][i][0]);
        end
        res = elem_t'(ones);
      end
      VEXT_X_V: res = (scalar < elem_t'(model_vl)) ? model_vrf[vs2][idx] : '0;
      default: begin
        // Only elements below vl change
        for (int i = 0; i < model_vl; i++) begin
          case (op)
            VMV_V_X: model_vrf[vd][i] = scalar;
            VADD_VV: model_vrf[vd][i] = model_vrf[vs1][i] + model_vrf[vs2][i];
            VADD_VX: model_vrf[vd][i] = model_vrf[vs2][i] + scalar;
            default: model_vrf[vd][i] = model_vrf[vs1][i] & model_vrf[vs2][i];
          endcase
        end
      end
    endcase
    ent.req.op     = op;
    ent.req.vd     = vreg_t'(vd);
    ent.req.vs1    = vreg_t'(vs1);
    ent.req.vs2    = vreg_t'(vs2);
    ent.req.scalar = scalar;
    ent.exp.result = res;
    stim_q.push_back(ent);
  endfunction

  function automatic void build_table();
    int    vl_list [5] = '{37, 6, 0, 11, 16};
    int    vd;
    int    va;
    int    vb;
    elem_t s;
    add_entry(VSETVL, 0, 0, 0, elem_t'(`VEC_VLMAX));
    // Every register gets a known value first
    for (int r = 0; r < `VEC_NR_VREGS; r++) begin
      add_entry(VMV_V_X, r, 0, 0, rand_elem());
    end
    foreach (vl_list[k]) begin
      add_entry(VSETVL, 0, 0, 0, elem_t'(vl_list[k]));
      va = rand_below(`VEC_NR_VREGS);
      vb = rand_below(`VEC_NR_VREGS);
      vd = rand_below(`VEC_NR_VREGS);
      add_entry(VADD_VV, vd, va, vb, '0);
      va = rand_below(`VEC_NR_VREGS);
      vd = rand_below(`VEC_NR_VREGS);
      s  = rand_elem();
      add_entry(VADD_VX, vd, 0, va, s);
      vd = rand_below(`VEC_NR_VREGS);
      s  = rand_elem();
      add_entry(VMV_V_X, vd, 0, 0, s);
      va = rand_below(`VEC_NR_VREGS);
      vb = rand_below(`VEC_NR_VREGS);
      vd = rand_below(`VEC_NR_VREGS);
      add_entry(VAND_VV, vd, va, vb, '0);
      add_entry(VCPOP, 0, 0, vd, '0);
      add_entry(VEXT_X_V, 0, 0, vd, elem_t'(rand_below(20)));
      // One past the last active element
      add_entry(VEXT_X_V, 0, 0, vd, elem_t'(model_vl));
      // Read the whole register back, tail included
      add_entry(VSETVL, 0, 0, 0, elem_t'(`VEC_VLMAX));
      for (int e = 0; e < `VEC_VLMAX; e++) begin
        add_entry(VEXT_X_V, 0, 0, vd, elem_t'(e));
      end
    end
    for (int r = 0; r < `VEC_NR_VREGS; r++) begin
      add_entry(VCPOP, 0, 0, r, '0);
      for (int e = 0; e < `VEC_VLMAX; e++) begin
        add_entry(VEXT_X_V, 0, 0, r, elem_t'(e));
      end
    end
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checks and host-side handshakes
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_resp(input acc_resp_t got, input acc_resp_t exp, input string what);
    if (got !== exp) begin
      resp_errors++;
      $display("FAIL @ %0t ns: %s returned %0h, expected %0h",
               $time, what, got.result, exp.result);
    end
  endtask

  task automatic check_ready(input logic exp, input string what);
    if (acc_req_ready_o !== exp) begin
      ready_errors++;
      $display("FAIL @ %0t ns: request ready is %b %s, expected %b",
               $time, acc_req_ready_o, what, exp);
    end
  endtask

  task automatic send_req(input acc_req_t req);
    @(posedge clk_i);
    acc_req_i       <= req;
    acc_req_valid_i <= 1'b1;
    @(negedge clk_i);
    while (acc_req_ready_o !== 1'b1) begin
      @(negedge clk_i);
    end
    // Accepted on this edge
    @(posedge clk_i);
    acc_req_valid_i <= 1'b0;
  endtask

  task automatic wait_resp(output acc_resp_t resp);
    int        stall;
    acc_resp_t held;
    @(negedge clk_i);
    while (acc_resp_valid_o !== 1'b1) begin
      check_ready(1'b0, "while busy");
      @(negedge clk_i);
    end
    held  = acc_resp_o;
    stall = rand_below(4);
    // Response must hold still while the host is not ready
    repeat (stall) begin
      check_ready(1'b0, "during back-pressure");
      @(negedge clk_i);
      if (acc_resp_valid_o !== 1'b1) begin
        proto_errors++;
        $display("FAIL @ %0t ns: response valid dropped while ready was low", $time);
      end
      check_resp(acc_resp_o, held, "held response");
    end
    @(posedge clk_i);
    acc_resp_ready_i <= 1'b1;
    @(posedge clk_i);
    acc_resp_ready_i <= 1'b0;
    resp = held;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    acc_resp_t got;
    int        total;
    rst_i            = 1'b1;
    acc_req_i        = '0;
    acc_req_valid_i  = 1'b0;
    acc_resp_ready_i = 1'b0;
    build_table();
    table_built = 1'b1;
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    check_ready(1'b1, "after reset");
    if (acc_resp_valid_o !== 1'b0) begin
      proto_errors++;
      $display("FAIL @ %0t ns: response valid is high after reset", $time);
    end
    foreach (stim_q[n]) begin
      send_req(stim_q[n].req);
      wait_resp(got);
      check_resp(got, stim_q[n].exp, $sformatf("entry %0d %s", n, stim_q[n].req.op.name()));
    end
    total = resp_errors + ready_errors + proto_errors;
    $display("Errors: %0d result, %0d ready, %0d protocol over %0d requests",
             resp_errors, ready_errors, proto_errors, stim_q.size());
    if (total == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    int limit;
    wait (table_built);
    limit = stim_q.size() * (`VEC_VLMAX + 20) + 10;
    repeat (limit) @(posedge clk_i);
    $display("Timeout: the DUT stopped answering after %0d cycles", limit);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

/* verilog/vec_top.sv */
// Vector accelerator top level
// Dispatcher, sequencer, replicated lanes and mask unit

`timescale 1ns/1ps
`include "vec_config.svh"

module vec_top import vec_isa_pkg::*, vec_lane_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  // Host
  input  acc_req_t  acc_req_i,
  input  logic      acc_req_valid_i,
  output logic      acc_req_ready_o,
  output acc_resp_t acc_resp_o,
  output logic      acc_resp_valid_o,
  input  logic      acc_resp_ready_i
);

  ////////////////////////////////////////////////////////////////////////////
  // Dispatcher and sequencer
  ////////////////////////////////////////////////////////////////////////////

  ara_req_t                             ara_req;
  logic                                 ara_req_valid;
  logic                                 ara_resp_valid;
  elem_t                                ara_resp_result;
  pe_req_t                              pe_req;
  logic                                 pe_req_valid;
  logic       [`VEC_NR_LANES-1:0]       lane_done;
  logic                                 masku_done;
  elem_t                                result_scalar;
  mask_opnd_t [`VEC_NR_LANES-1:0]       mask_opnd;
  logic       [`VEC_NR_LANES-1:0]       mask_opnd_valid;

  vec_dispatcher vec_dispatcher_inst (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .acc_req_i         (acc_req_i),
    .acc_req_valid_i   (acc_req_valid_i),
    .acc_req_ready_o   (acc_req_ready_o),
    .acc_resp_o        (acc_resp_o),
    .acc_resp_valid_o  (acc_resp_valid_o),
    .acc_resp_ready_i  (acc_resp_ready_i),
    .ara_req_o         (ara_req),
    .ara_req_valid_o   (ara_req_valid),
    .ara_resp_valid_i  (ara_resp_valid),
    .ara_resp_result_i (ara_resp_result)
  );

  vec_sequencer vec_sequencer_inst (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .ara_req_i         (ara_req),
    .ara_req_valid_i   (ara_req_valid),
    .ara_resp_valid_o  (ara_resp_valid),
    .ara_resp_result_o (ara_resp_result),
    .pe_req_o          (pe_req),
    .pe_req_valid_o    (pe_req_valid),
    .lane_done_i       (lane_done),
    .masku_done_i      (masku_done),
    .result_scalar_i   (result_scalar)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Lanes and mask unit
  ////////////////////////////////////////////////////////////////////////////

  for (genvar l = 0; l < `VEC_NR_LANES; l++) begin : gen_lanes
    vec_lane #(
      .LANE_ID (l)
    ) vec_lane_inst (
      .clk_i             (clk_i),
      .rst_i             (rst_i),
      .pe_req_i          (pe_req),
      .pe_req_valid_i    (pe_req_valid),
      .lane_done_o       (lane_done[l]),
      .mask_opnd_o       (mask_opnd[l]),
      .mask_opnd_valid_o (mask_opnd_valid[l])
    );
  end

  vec_masku vec_masku_inst (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .pe_req_i          (pe_req),
    .pe_req_valid_i    (pe_req_valid),
    .mask_opnd_i       (mask_opnd),
    .mask_opnd_valid_i (mask_opnd_valid),
    .masku_done_o      (masku_done),
    .result_scalar_o   (result_scalar)
  );

endmodule

/* verilog/vec_masku.sv */
// Vector mask unit
// Reduces lane operands into the scalar result of VCPOP or VEXT_X_V

`timescale 1ns/1ps
`include "vec_config.svh"

module vec_masku import vec_isa_pkg::*, vec_lane_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_i,
  // Sequencer
  input  pe_req_t                        pe_req_i,
  input  logic                           pe_req_valid_i,
  // Lanes
  input  mask_opnd_t [`VEC_NR_LANES-1:0] mask_opnd_i,
  input  logic       [`VEC_NR_LANES-1:0] mask_opnd_valid_i,
  // Result
  output logic                           masku_done_o,
  output elem_t                          result_scalar_o
);

  logic    active_q;
  logic    done_q;
  vec_op_e op_q;
  vlen_t   vl_q;
  elem_t   idx_q;
  vlen_t   cnt_q;
  vlen_t   ones_q;
  elem_t   ext_q;
  elem_t   result_q;
  vlen_t   beat_cnt;
  vlen_t   beat_ones;
  logic    ext_hit;
  elem_t   ext_val;
  vlen_t   cnt_d;
  vlen_t   ones_d;
  elem_t   ext_d;
  logic    start;
  logic    last_beat;

  assign start = pe_req_valid_i & (pe_req_i.op inside {VCPOP, VEXT_X_V});

  // Count this cycle's operands and look for the requested element
  always_comb begin
    beat_cnt  = '0;
    beat_ones = '0;
    ext_hit   = 1'b0;
    ext_val   = '0;
    for (int l = 0; l < `VEC_NR_LANES; l++) begin
      if (mask_opnd_valid_i[l]) begin
        beat_cnt  = beat_cnt + vlen_t'(1);
        beat_ones = beat_ones + vlen_t'(mask_opnd_i[l].elem[0]);
        // Element index is row * lanes + lane
        if (elem_t'(int'(mask_opnd_i[l].row) * `VEC_NR_LANES + l) == idx_q) begin
          ext_hit = 1'b1;
          ext_val = mask_opnd_i[l].elem;
        end
      end
    end
  end

  assign cnt_d     = cnt_q + beat_cnt;
  assign ones_d    = ones_q + beat_ones;
  // An index at or beyond vl never matches and leaves zero
  assign ext_d     = ext_hit ? ext_val : ext_q;
  assign last_beat = active_q && (cnt_d == vl_q);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      active_q <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start) begin
        active_q <= (pe_req_i.vl != '0);
        done_q   <= (pe_req_i.vl == '0);
      end else if (last_beat) begin
        active_q <= 1'b0;
        done_q   <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      op_q     <= pe_req_i.op;
      vl_q     <= pe_req_i.vl;
      idx_q    <= pe_req_i.scalar;
      cnt_q    <= '0;
      ones_q   <= '0;
      ext_q    <= '0;
      result_q <= '0;
    end else if (active_q) begin
      cnt_q  <= cnt_d;
      ones_q <= ones_d;
      ext_q  <= ext_d;
      if (last_beat) begin
        result_q <= (op_q == VCPOP) ? elem_t'(ones_d) : ext_d;
      end
    end
  end

  assign masku_done_o    = done_q;
  assign result_scalar_o = result_q;

endmodule

/* verilog/vec_lane.sv */
// Vector lane
// Register file slice, element ALU and operand output towards the mask unit

`timescale 1ns/1ps
`include "vec_config.svh"

module vec_lane import vec_isa_pkg::*, vec_lane_pkg::*; #(
  parameter int unsigned LANE_ID = 0
) (
  input  logic       clk_i,
  input  logic       rst_i,
  // Sequencer
  input  pe_req_t    pe_req_i,
  input  logic       pe_req_valid_i,
  output logic       lane_done_o,
  // Mask unit
  output mask_opnd_t mask_opnd_o,
  output logic       mask_opnd_valid_o
);

  localparam int unsigned ROW_CNT_W = $clog2(`VEC_ROWS + 1);
  localparam int unsigned SPAN_W    = $bits(vlen_t) + 1;

  typedef logic [ROW_CNT_W-1:0] row_cnt_t;

  // Element i of each register lives here at row i / lanes
  elem_t vrf_q [`VEC_NR_VREGS][`VEC_ROWS];

  pe_req_t             req_q;
  logic                active_q;
  row_t                row_q;
  row_cnt_t            nrows_q;
  logic [SPAN_W-1:0]   row_span;
  row_cnt_t            nrows_d;
  logic                last_row;
  logic                is_mask_op;
  elem_t               opnd_a;
  elem_t               opnd_b;
  elem_t               alu_res;
  logic                wr_en_q;
  logic                opnd_valid_q;
  logic                done_q;
  row_t                wr_row_q;
  elem_t               wr_data_q;

  // Rows in this lane are ceil((vl - LANE_ID) / lanes)
  // None when vl <= LANE_ID
  assign row_span = {1'b0, pe_req_i.vl} + SPAN_W'(`VEC_NR_LANES - 1 - LANE_ID);
  assign nrows_d  = row_cnt_t'(row_span / `VEC_NR_LANES);

  assign last_row   = ((row_cnt_t'(row_q) + row_cnt_t'(1)) == nrows_q);
  assign is_mask_op = req_q.op inside {VCPOP, VEXT_X_V};

  ////////////////////////////////////////////////////////////////////////////
  // Read and execute stage
  ////////////////////////////////////////////////////////////////////////////

  assign opnd_a = vrf_q[req_q.vs1][row_q];
  assign opnd_b = vrf_q[req_q.vs2][row_q];

  always_comb begin
    case (req_q.op)
      VMV_V_X: alu_res = req_q.scalar;
      VADD_VV: alu_res = opnd_a + opnd_b;
      VADD_VX: alu_res = opnd_b + req_q.scalar;
      VAND_VV: alu_res = opnd_a & opnd_b;
      // Mask unit operations pass vs2 through
      default: alu_res = opnd_b;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      active_q     <= 1'b0;
      row_q        <= '0;
      nrows_q      <= '0;
      wr_en_q      <= 1'b0;
      opnd_valid_q <= 1'b0;
      done_q       <= 1'b0;
    end else begin
      wr_en_q      <= active_q & ~is_mask_op;
      opnd_valid_q <= active_q & is_mask_op;
      // Done with the last row, or right away when the lane holds no element
      done_q       <= (pe_req_valid_i && nrows_d == '0) || (active_q && last_row);
      if (pe_req_valid_i) begin
        active_q <= (nrows_d != '0);
        row_q    <= '0;
        nrows_q  <= nrows_d;
      end else if (active_q) begin
        active_q <= ~last_row;
        row_q    <= row_q + row_t'(1);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Write-back stage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (pe_req_valid_i) begin
      req_q <= pe_req_i;
    end
    wr_row_q  <= row_q;
    wr_data_q <= alu_res;
    if (wr_en_q) begin
      vrf_q[req_q.vd][wr_row_q] <= wr_data_q;
    end
  end

  assign lane_done_o       = done_q;
  assign mask_opnd_o       = '{elem: wr_data_q, row: wr_row_q};
  assign mask_opnd_valid_o = opnd_valid_q;

endmodule

/* verilog/vec_sequencer.sv */
// Vector sequencer
// Broadcasts each instruction to the lanes and mask unit, then waits for completion

`timescale 1ns/1ps
`include "vec_config.svh"

module vec_sequencer import vec_isa_pkg::*, vec_lane_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_i,
  // Dispatcher
  input  ara_req_t                 ara_req_i,
  input  logic                     ara_req_valid_i,
  output logic                     ara_resp_valid_o,
  output elem_t                    ara_resp_result_o,
  // Lanes and mask unit
  output pe_req_t                  pe_req_o,
  output logic                     pe_req_valid_o,
  input  logic [`VEC_NR_LANES-1:0] lane_done_i,
  input  logic                     masku_done_i,
  input  elem_t                    result_scalar_i
);

  pe_req_t                  pe_req_q;
  logic                     pe_req_valid_q;
  logic                     busy_q;
  logic [`VEC_NR_LANES-1:0] done_q;
  logic [`VEC_NR_LANES-1:0] done_seen;
  logic                     resp_valid_q;
  elem_t                    resp_result_q;
  logic                     is_mask_op;
  logic                     finish;

  // Sticky done bits with this cycle's pulses included
  assign done_seen = done_q | lane_done_i;

  // Scalar results come from the mask unit
  assign is_mask_op = pe_req_q.op inside {VCPOP, VEXT_X_V};

  assign finish = busy_q & (is_mask_op ? masku_done_i : &done_seen);

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pe_req_valid_q <= 1'b0;
      busy_q         <= 1'b0;
      done_q         <= '0;
      resp_valid_q   <= 1'b0;
    end else begin
      // Broadcast for exactly one cycle
      pe_req_valid_q <= ara_req_valid_i;
      resp_valid_q   <= finish;
      if (ara_req_valid_i) begin
        busy_q <= 1'b1;
        done_q <= '0;
      end else if (busy_q) begin
        busy_q <= ~finish;
        done_q <= done_seen;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ara_req_valid_i) begin
      pe_req_q <= '{op: ara_req_i.op, vd: ara_req_i.vd, vs1: ara_req_i.vs1,
                    vs2: ara_req_i.vs2, scalar: ara_req_i.scalar, vl: ara_req_i.vl};
    end
    if (finish) begin
      // Vector operations answer with zero
      resp_result_q <= is_mask_op ? result_scalar_i : '0;
    end
  end

  assign pe_req_o          = pe_req_q;
  assign pe_req_valid_o    = pe_req_valid_q;
  assign ara_resp_valid_o  = resp_valid_q;
  assign ara_resp_result_o = resp_result_q;

endmodule

/* verilog/vec_dispatcher.sv */
// Vector dispatcher
// Host handshake, vector length state and response formation

`timescale 1ns/1ps
`include "vec_config.svh"

module vec_dispatcher import vec_isa_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  // Host request and response
  input  acc_req_t  acc_req_i,
  input  logic      acc_req_valid_i,
  output logic      acc_req_ready_o,
  output acc_resp_t acc_resp_o,
  output logic      acc_resp_valid_o,
  input  logic      acc_resp_ready_i,
  // Sequencer
  output ara_req_t  ara_req_o,
  output logic      ara_req_valid_o,
  input  logic      ara_resp_valid_i,
  input  elem_t     ara_resp_result_i
);

  typedef enum logic [1:0] {
    DISP_IDLE,
    DISP_WAIT,
    DISP_RESP
  } disp_state_e;

  disp_state_e state_q;
  vlen_t       vl_q;
  vlen_t       vl_new;
  ara_req_t    ara_req_q;
  logic        ara_req_valid_q;
  acc_resp_t   resp_q;
  logic        accept;
  logic        is_setvl;

  assign accept   = acc_req_valid_i & acc_req_ready_o;
  assign is_setvl = (acc_req_i.op == VSETVL);

  // Requested length clamped to VLMAX
  assign vl_new = (acc_req_i.scalar > elem_t'(`VEC_VLMAX)) ? vlen_t'(`VEC_VLMAX) :
                  vlen_t'(acc_req_i.scalar);

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q         <= DISP_IDLE;
      vl_q            <= vlen_t'(`VEC_VLMAX);
      ara_req_valid_q <= 1'b0;
    end else begin
      ara_req_valid_q <= accept & ~is_setvl;
      case (state_q)
        DISP_IDLE: begin
          if (accept) begin
            if (is_setvl) begin
              vl_q    <= vl_new;
              state_q <= DISP_RESP;
            end else begin
              state_q <= DISP_WAIT;
            end
          end
        end
        DISP_WAIT: begin
          if (ara_resp_valid_i) begin
            state_q <= DISP_RESP;
          end
        end
        DISP_RESP: begin
          // Held until the host takes it
          if (acc_resp_ready_i) begin
            state_q <= DISP_IDLE;
          end
        end
        default: state_q <= DISP_IDLE;
      endcase
    end
  end

  // Forwarded request and response payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      ara_req_q <= '{op: acc_req_i.op, vd: acc_req_i.vd, vs1: acc_req_i.vs1,
                     vs2: acc_req_i.vs2, scalar: acc_req_i.scalar, vl: vl_q};
    end
    if (accept && is_setvl) begin
      resp_q <= '{result: elem_t'(vl_new)};
    end else if (state_q == DISP_WAIT && ara_resp_valid_i) begin
      resp_q <= '{result: ara_resp_result_i};
    end
  end

  assign acc_req_ready_o  = (state_q == DISP_IDLE);
  assign acc_resp_valid_o = (state_q == DISP_RESP);
  assign acc_resp_o       = resp_q;
  assign ara_req_o        = ara_req_q;
  assign ara_req_valid_o  = ara_req_valid_q;

endmodule

/* verilog/vec_lane_pkg.sv */
// Vector accelerator lane-side types
// Traffic between the sequencer, the lanes and the mask unit

`include "vec_config.svh"

package vec_lane_pkg;

  import vec_isa_pkg::*;

  // Row index inside one lane
  typedef logic [$clog2(`VEC_ROWS)-1:0] row_t;

  // Broadcast request from the sequencer
  typedef struct packed {
    vec_op_e op;
    vreg_t   vd;
    vreg_t   vs1;
    vreg_t   vs2;
    elem_t   scalar;
    vlen_t   vl;
  } pe_req_t;

  // One element sent from a lane to the mask unit
  // The lane index is implied by the port it arrives on
  typedef struct packed {
    elem_t elem;
    row_t  row;
  } mask_opnd_t;

endpackage

/* verilog/vec_isa_pkg.sv */
// Vector accelerator instruction-level types
// Shared by the host port, the dispatcher and the sequencer

`include "vec_config.svh"

package vec_isa_pkg;

  // Supported instructions
  typedef enum logic [2:0] {
    VSETVL   = 3'd0,
    VMV_V_X  = 3'd1,
    VADD_VV  = 3'd2,
    VADD_VX  = 3'd3,
    VAND_VV  = 3'd4,
    VCPOP    = 3'd5,
    VEXT_X_V = 3'd6
  } vec_op_e;

  typedef logic [`VEC_ELEN-1:0]               elem_t;
  typedef logic [$clog2(`VEC_NR_VREGS)-1:0]   vreg_t;
  // Holds 0 up to and including VLMAX
  typedef logic [$clog2(`VEC_VLMAX + 1)-1:0]  vlen_t;

  // Request from the host
  typedef struct packed {
    vec_op_e op;
    vreg_t   vd;
    vreg_t   vs1;
    vreg_t   vs2;
    elem_t   scalar;
  } acc_req_t;

  typedef struct packed {
    elem_t result;
  } acc_resp_t;

  // Host request with the current vector length attached
  typedef struct packed {
    vec_op_e op;
    vreg_t   vd;
    vreg_t   vs1;
    vreg_t   vs2;
    elem_t   scalar;
    vlen_t   vl;
  } ara_req_t;

endpackage

/* verilog/vec_config.svh */
// Vector accelerator configuration
// Lane count, element width, register count and vector length limits

`ifndef VEC_CONFIG_SVH
`define VEC_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Lane geometry
////////////////////////////////////////////////////////////////////////////

// Number of parallel lanes
// At least one lane, a power of two, and no larger than VEC_VLMAX
`define VEC_NR_LANES 4

// Element width in bits
`define VEC_ELEN 32

////////////////////////////////////////////////////////////////////////////
// Register file
////////////////////////////////////////////////////////////////////////////

// Architectural vector registers
`define VEC_NR_VREGS 8

// Maximum vector length in elements
// Must be a multiple of VEC_NR_LANES
`define VEC_VLMAX 16

// Rows held by each lane
// Element i sits at row i / VEC_NR_LANES
`define VEC_ROWS (`VEC_VLMAX / `VEC_NR_LANES)

`endif
